/* Bender.yml */
package:
  name: umtrx_ctrl

sources:
  # Packages first, the register map uses the channel count
  - src/umtrx_sample_pkg.sv
  - src/umtrx_regmap_pkg.sv
  - src/umtrx_settings_bus.sv
  - src/umtrx_rx_chan_ctrl.sv
  - src/umtrx_misc_regs.sv
  - src/umtrx_ctrl_top.sv
  - target: test
    files:
      - verif/umtrx_ctrl_tb.sv

/* src/umtrx_ctrl_top.sv */
// Control-plane top: bus-to-settings converter, the receive channel
// controllers and the misc registers, tied together by the settings bus.
`timescale 1ns/1ps

module umtrx_ctrl_top (
   input  logic                                     wb_clk,
   input  logic                                     por_rst,
   // Bus slave port
   input  logic                                     wb_stb_i,
   input  logic                                     wb_we_i,
   input  logic [umtrx_regmap_pkg::WB_ADR_W-1:0]    wb_adr_i,
   input  logic [umtrx_regmap_pkg::SET_DATA_W-1:0]  wb_dat_i,
   output logic                                     wb_ack_o,
   output logic [umtrx_regmap_pkg::SET_DATA_W-1:0]  wb_dat_o,
   // ADC frontends
   input  logic [umtrx_sample_pkg::ADC_W-1:0]       adc0_a_i,
   input  logic [umtrx_sample_pkg::ADC_W-1:0]       adc0_b_i,
   input  logic [umtrx_sample_pkg::ADC_W-1:0]       adc1_a_i,
   input  logic [umtrx_sample_pkg::ADC_W-1:0]       adc1_b_i,
   input  logic                                     adc0_stb_i,
   input  logic                                     adc1_stb_i,
   // Per-channel samples
   output logic [umtrx_sample_pkg::FRONT_W-1:0]     front_i_o [umtrx_sample_pkg::NUM_RX_CHAN],
   output logic [umtrx_sample_pkg::FRONT_W-1:0]     front_q_o [umtrx_sample_pkg::NUM_RX_CHAN],
   output logic [umtrx_sample_pkg::NUM_RX_CHAN-1:0] sample_stb_o,
   // Misc
   output logic [7:0]                               leds_o,
   output logic                                     divsw1_o,
   output logic                                     divsw2_o,
   output logic                                     run_rx0_o,
   output logic                                     run_rx1_o
);
   import umtrx_regmap_pkg::*;
   import umtrx_sample_pkg::*;

   logic                   set_stb;
   logic [SET_ADDR_W-1:0]  set_addr;
   logic [SET_DATA_W-1:0]  set_data;
   logic [NUM_RX_CHAN-1:0] chan_run;
   logic [NUM_RX_CHAN-1:0] chan_fe_sel;

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus
   umtrx_settings_bus u_settings_bus (
      .wb_clk     (wb_clk),
      .por_rst    (por_rst),
      .wb_stb_i   (wb_stb_i),
      .wb_we_i    (wb_we_i),
      .wb_adr_i   (wb_adr_i),
      .wb_dat_i   (wb_dat_i),
      .wb_ack_o   (wb_ack_o),
      .wb_dat_o   (wb_dat_o),
      .set_stb_o  (set_stb),
      .set_addr_o (set_addr),
      .set_data_o (set_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Receive channels, all see both frontends
   for (genvar ch = 0; ch < NUM_RX_CHAN; ch++) begin : g_rx_chan
      umtrx_rx_chan_ctrl #(
         .CHAN_NO (ch)
      ) u_rx_chan (
         .wb_clk       (wb_clk),
         .por_rst      (por_rst),
         .set_stb_i    (set_stb),
         .set_addr_i   (set_addr),
         .set_data_i   (set_data),
         .adc0_a_i     (adc0_a_i),
         .adc0_b_i     (adc0_b_i),
         .adc1_a_i     (adc1_a_i),
         .adc1_b_i     (adc1_b_i),
         .adc0_stb_i   (adc0_stb_i),
         .adc1_stb_i   (adc1_stb_i),
         .front_i_o    (front_i_o[ch]),
         .front_q_o    (front_q_o[ch]),
         .sample_stb_o (sample_stb_o[ch]),
         .run_o        (chan_run[ch]),
         .fe_sel_o     (chan_fe_sel[ch])
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // LEDs and diversity switches
   umtrx_misc_regs u_misc_regs (
      .wb_clk        (wb_clk),
      .por_rst       (por_rst),
      .set_stb_i     (set_stb),
      .set_addr_i    (set_addr),
      .set_data_i    (set_data),
      .chan_run_i    (chan_run),
      .chan_fe_sel_i (chan_fe_sel),
      .leds_o        (leds_o),
      .divsw1_o      (divsw1_o),
      .divsw2_o      (divsw2_o),
      .run_rx0_o     (run_rx0_o),
      .run_rx1_o     (run_rx1_o)
   );

endmodule

/* src/umtrx_misc_regs.sv */
// LED and diversity-switch registers, plus the map from running channels
// onto the two frontend activity flags that drive the hardware LEDs.
`timescale 1ns/1ps

module umtrx_misc_regs (
   input  logic                                     wb_clk,
   input  logic                                     por_rst,
   input  logic                                     set_stb_i,
   input  logic [umtrx_regmap_pkg::SET_ADDR_W-1:0]  set_addr_i,
   input  logic [umtrx_regmap_pkg::SET_DATA_W-1:0]  set_data_i,
   input  logic [umtrx_sample_pkg::NUM_RX_CHAN-1:0] chan_run_i,
   input  logic [umtrx_sample_pkg::NUM_RX_CHAN-1:0] chan_fe_sel_i,
   output logic [7:0]                               leds_o,
   output logic                                     divsw1_o,
   output logic                                     divsw2_o,
   output logic                                     run_rx0_o,
   output logic                                     run_rx1_o
);
   import umtrx_regmap_pkg::*;
   import umtrx_sample_pkg::*;

   set_word_u              misc_word;
   logic [7:0]             led_sw;
   logic [7:0]             led_src;
   logic [7:0]             led_hw;
   logic [NUM_FRONT-1:0]   fe_active;

   assign misc_word = set_data_i;

   ////////////////////////////////////////////////////////////////////////////
   // Registers
   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         led_sw   <= '0;
         led_src  <= LED_SRC_AT_RESET;
         divsw1_o <= DIVSW_AT_RESET;
         divsw2_o <= DIVSW_AT_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_LED_SW:       led_sw   <= misc_word.led.led_byte;
            SR_LED_SRC:      led_src  <= misc_word.led.led_byte;
            SR_DIVSW:        divsw1_o <= misc_word.led.led_byte[0];
            SR_DIVSW + 8'd1: divsw2_o <= misc_word.led.led_byte[0];
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Frontend activity

   // A frontend is busy when any running channel points at it
   always_comb begin
      fe_active = '0;
      for (int ch = 0; ch < NUM_RX_CHAN; ch++) begin
         if (chan_run_i[ch]) begin
            fe_active[chan_fe_sel_i[ch]] = 1'b1;
         end
      end
   end

   assign run_rx0_o = fe_active[0];
   assign run_rx1_o = fe_active[1];

   // Hardware LED word, only the two activity positions are used
   always_comb begin
      led_hw = '0;
      led_hw[LED_HW_RX0_BIT] = run_rx0_o;
      led_hw[LED_HW_RX1_BIT] = run_rx1_o;
   end

   // Mask bit 1 = hardware, 0 = software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

/* src/umtrx_regmap_pkg.sv */
// Settings-bus register map of the control plane, shared by every settings receiver.
// Also holds the union that decodes one settings data word in its two layouts.
package umtrx_regmap_pkg;

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   // Byte address on the bus side, the settings address is bits 9..2
   localparam int WB_ADR_W = 10;

   ////////////////////////////////////////////////////////////////////////////
   // Register addresses
   localparam logic [SET_ADDR_W-1:0] SR_LED_SW  = 8'd3;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SRC = 8'd6;
   // Switch 2 sits at the next address
   localparam logic [SET_ADDR_W-1:0] SR_DIVSW   = 8'd180;

   // One control word per receive channel, not contiguous
   localparam logic [SET_ADDR_W-1:0] SR_RX_CTRL [umtrx_sample_pkg::NUM_RX_CHAN] =
      '{8'd32, 8'd80, 8'd66, 8'd83};

   ////////////////////////////////////////////////////////////////////////////
   // Reset values and LED layout
   localparam logic [7:0] LED_SRC_AT_RESET = 8'h1E;
   localparam logic       DIVSW_AT_RESET   = 1'b1;

   localparam int LED_HW_RX0_BIT = 3;
   localparam int LED_HW_RX1_BIT = 1;

   ////////////////////////////////////////////////////////////////////////////
   // Settings data word views
   typedef struct packed {
      logic [23:0] unused;
      logic [7:0]  led_byte;
   } led_view_t;

   typedef struct packed {
      logic [29:0] unused;
      logic        fe_sel;
      logic        run;
   } chan_view_t;

   typedef union packed {
      led_view_t  led;
      chan_view_t chan;
   } set_word_u;

endpackage

/* src/umtrx_rx_chan_ctrl.sv */
// One receive channel: control register with run and frontend select, plus
// the sample path that picks, pads and registers the chosen ADC pair.
`timescale 1ns/1ps

module umtrx_rx_chan_ctrl #(
   parameter int CHAN_NO = 0
) (
   input  logic                                    wb_clk,
   input  logic                                    por_rst,
   input  logic                                    set_stb_i,
   input  logic [umtrx_regmap_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [umtrx_regmap_pkg::SET_DATA_W-1:0] set_data_i,
   input  logic [umtrx_sample_pkg::ADC_W-1:0]      adc0_a_i,
   input  logic [umtrx_sample_pkg::ADC_W-1:0]      adc0_b_i,
   input  logic [umtrx_sample_pkg::ADC_W-1:0]      adc1_a_i,
   input  logic [umtrx_sample_pkg::ADC_W-1:0]      adc1_b_i,
   input  logic                                    adc0_stb_i,
   input  logic                                    adc1_stb_i,
   output logic [umtrx_sample_pkg::FRONT_W-1:0]    front_i_o,
   output logic [umtrx_sample_pkg::FRONT_W-1:0]    front_q_o,
   output logic                                    sample_stb_o,
   output logic                                    run_o,
   output logic                                    fe_sel_o
);
   import umtrx_regmap_pkg::*;
   import umtrx_sample_pkg::*;

   // ADC word moved up by the pad bits, zero above the 16-bit value
   function automatic logic [FRONT_W-1:0] pad_adc(input logic [ADC_W-1:0] adc);
      logic [FRONT_W-1:0] word;
      word = '0;
      word[ADC_W+FRONT_PAD_W-1:FRONT_PAD_W] = adc;
      return word;
   endfunction

   set_word_u          ctrl_word;
   logic [ADC_W-1:0]   sel_a;
   logic [ADC_W-1:0]   sel_b;
   logic               sel_stb;
   logic               take;

   assign ctrl_word = set_data_i;

   ////////////////////////////////////////////////////////////////////////////
   // Control register
   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         run_o    <= 1'b0;
         fe_sel_o <= 1'b0;
      end else if (set_stb_i && set_addr_i == SR_RX_CTRL[CHAN_NO]) begin
         run_o    <= ctrl_word.chan.run;
         fe_sel_o <= ctrl_word.chan.fe_sel;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Frontend select and sample register
   assign sel_a   = fe_sel_o ? adc1_a_i : adc0_a_i;
   assign sel_b   = fe_sel_o ? adc1_b_i : adc0_b_i;
   assign sel_stb = fe_sel_o ? adc1_stb_i : adc0_stb_i;

   // Stopped channel ignores its frontend
   assign take = sel_stb & run_o;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         sample_stb_o <= 1'b0;
      end else begin
         sample_stb_o <= take;
      end
   end

   // I/Q hold their last sample between strobes
   always_ff @(posedge wb_clk) begin
      if (take) begin
         front_i_o <= pad_adc(sel_a);
         front_q_o <= pad_adc(sel_b);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks

   // A sample only leaves if run was set on the edge that captured it
   a_stb_needs_run : assert property (
      @(posedge wb_clk) disable iff (por_rst)
      sample_stb_o |-> $past(run_o)
   );

endmodule

/* src/umtrx_sample_pkg.sv */
// Sample widths and channel counts of the receive side.
// Used by the channel controllers, the misc registers and the top level.
package umtrx_sample_pkg;

   // Raw converter word per lane
   localparam int ADC_W = 12;

   // Frontend sample handed to the DSP chain
   localparam int FRONT_W = 24;

   // Zero bits appended below the ADC word, giving a 16-bit value
   localparam int FRONT_PAD_W = 4;

   // Receive DSP channels
   localparam int NUM_RX_CHAN = 4;

   // ADC frontends a channel can pick from
   localparam int NUM_FRONT = 2;

endpackage

/* src/umtrx_settings_bus.sv */
// Bus slave that turns each write access into a one-cycle settings-bus strobe.
// Reads are acknowledged the same way and always return zero.
`timescale 1ns/1ps

module umtrx_settings_bus (
   input  logic                                    wb_clk,
   input  logic                                    por_rst,
   input  logic                                    wb_stb_i,
   input  logic                                    wb_we_i,
   input  logic [umtrx_regmap_pkg::WB_ADR_W-1:0]   wb_adr_i,
   input  logic [umtrx_regmap_pkg::SET_DATA_W-1:0] wb_dat_i,
   output logic                                    wb_ack_o,
   output logic [umtrx_regmap_pkg::SET_DATA_W-1:0] wb_dat_o,
   output logic                                    set_stb_o,
   output logic [umtrx_regmap_pkg::SET_ADDR_W-1:0] set_addr_o,
   output logic [umtrx_regmap_pkg::SET_DATA_W-1:0] set_data_o
);
   import umtrx_regmap_pkg::*;

   logic access;
   logic wr_access;

   // New access only while no ack is out
   assign access    = wb_stb_i & ~wb_ack_o;
   assign wr_access = access & wb_we_i;

   ////////////////////////////////////////////////////////////////////////////
   // Handshake and strobe
   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         wb_ack_o  <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         wb_ack_o  <= access;
         set_stb_o <= wr_access;
      end
   end

   // Word address drops the two byte-lane bits
   always_ff @(posedge wb_clk) begin
      if (wr_access) begin
         set_addr_o <= wb_adr_i[WB_ADR_W-1:2];
         set_data_o <= wb_dat_i;
      end
   end

   // Nothing readable behind this port
   assign wb_dat_o = '0;

   ////////////////////////////////////////////////////////////////////////////
   // Checks

   // Master drops stb after ack, so acks come at least one idle cycle apart
   a_ack_single : assert property (
      @(posedge wb_clk) disable iff (por_rst)
      wb_ack_o |=> !wb_ack_o
   );

endmodule

/* umtrx_ctrl.f */
src/umtrx_sample_pkg.sv
src/umtrx_regmap_pkg.sv
src/umtrx_settings_bus.sv
src/umtrx_rx_chan_ctrl.sv
src/umtrx_misc_regs.sv
src/umtrx_ctrl_top.sv
verif/umtrx_ctrl_tb.sv

/* verif/umtrx_ctrl_tb.sv */
// Random-stimulus testbench for the control-plane top level.
// Drives bus accesses and ADC samples, and checks the DUT against a local model.
`timescale 1ns/1ps

module umtrx_ctrl_tb;
   import umtrx_regmap_pkg::*;
   import umtrx_sample_pkg::*;

   localparam int ACK_TIMEOUT   = 20;
   localparam int MISC_WRITES   = 40;
   localparam int CHAN_ROUNDS   = 8;
   localparam int SAMPLE_CYCLES = 60;
   localparam int FLAG_ROUNDS   = 30;
   localparam int ODD_ACCESSES  = 30;

   logic                   wb_clk = 1'b0;
   logic                   por_rst;
   logic                   wb_stb;
   logic                   wb_we;
   logic                   wb_ack;
   logic [WB_ADR_W-1:0]    wb_adr;
   logic [SET_DATA_W-1:0]  wb_dat_w;
   logic [SET_DATA_W-1:0]  wb_dat_r;
   logic [ADC_W-1:0]       adc0_a;
   logic [ADC_W-1:0]       adc0_b;
   logic [ADC_W-1:0]       adc1_a;
   logic [ADC_W-1:0]       adc1_b;
   logic                   adc0_stb;
   logic                   adc1_stb;
   logic [FRONT_W-1:0]     front_i [NUM_RX_CHAN];
   logic [FRONT_W-1:0]     front_q [NUM_RX_CHAN];
   logic [NUM_RX_CHAN-1:0] sample_stb;
   logic [7:0]             leds;
   logic                   divsw1;
   logic                   divsw2;
   logic                   run_rx0;
   logic                   run_rx1;

   logic [31:0]            rng_state = 32'h80e5;
   // Model of the registers and of the last captured samples
   logic [NUM_RX_CHAN-1:0] m_run;
   logic [NUM_RX_CHAN-1:0] m_sel;
   logic [NUM_RX_CHAN-1:0] have_sample;
   logic [7:0]             m_led_sw;
   logic [7:0]             m_led_src;
   logic                   m_divsw1;
   logic                   m_divsw2;
   logic [FRONT_W-1:0]     exp_i [NUM_RX_CHAN];
   logic [FRONT_W-1:0]     exp_q [NUM_RX_CHAN];
   int                     err_count;
   int                     tests_run;
   int                     tests_failed;
   int                     test_err_base;

   always #4 wb_clk = ~wb_clk;

   umtrx_ctrl_top dut_i (
      .wb_clk       (wb_clk),
      .por_rst      (por_rst),
      .wb_stb_i     (wb_stb),
      .wb_we_i      (wb_we),
      .wb_adr_i     (wb_adr),
      .wb_dat_i     (wb_dat_w),
      .wb_ack_o     (wb_ack),
      .wb_dat_o     (wb_dat_r),
      .adc0_a_i     (adc0_a),
      .adc0_b_i     (adc0_b),
      .adc1_a_i     (adc1_a),
      .adc1_b_i     (adc1_b),
      .adc0_stb_i   (adc0_stb),
      .adc1_stb_i   (adc1_stb),
      .front_i_o    (front_i),
      .front_q_o    (front_q),
      .sample_stb_o (sample_stb),
      .leds_o       (leds),
      .divsw1_o     (divsw1),
      .divsw2_o     (divsw2),
      .run_rx0_o    (run_rx0),
      .run_rx1_o    (run_rx1)
   );

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // ADC word over four zero bits, zero above the 16-bit value
   function automatic logic [FRONT_W-1:0] pad_sample(input logic [ADC_W-1:0] adc);
      return {8'h00, adc, 4'h0};
   endfunction

   function automatic logic [7:0] expected_leds();
      logic [7:0] hw;
      logic [7:0] leds_exp;
      hw = '0;
      hw[LED_HW_RX0_BIT] = |(m_run & ~m_sel);
      hw[LED_HW_RX1_BIT] = |(m_run & m_sel);
      // Source mask picks hardware or software per bit
      for (int b = 0; b < 8; b++) begin
         leds_exp[b] = m_led_src[b] ? hw[b] : m_led_sw[b];
      end
      return leds_exp;
   endfunction

   function automatic logic is_mapped(input logic [7:0] addr);
      logic hit;
      hit = (addr == SR_LED_SW) || (addr == SR_LED_SRC) ||
            (addr == SR_DIVSW) || (addr == SR_DIVSW + 8'd1);
      for (int ch = 0; ch < NUM_RX_CHAN; ch++) begin
         hit = hit || (addr == SR_RX_CTRL[ch]);
      end
      return hit;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_count++;
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $finish;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (err_count == test_err_base) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, err_count - test_err_base);
      end
      test_err_base = err_count;
   endtask

   task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
      if (addr == SR_LED_SW) m_led_sw = data[7:0];
      if (addr == SR_LED_SRC) m_led_src = data[7:0];
      if (addr == SR_DIVSW) m_divsw1 = data[0];
      if (addr == SR_DIVSW + 8'd1) m_divsw2 = data[0];
      for (int ch = 0; ch < NUM_RX_CHAN; ch++) begin
         if (addr == SR_RX_CTRL[ch]) begin
            m_run[ch] = data[0];
            m_sel[ch] = data[1];
         end
      end
   endtask

   task automatic check_misc();
      if (leds !== expected_leds()) report_mismatch("leds_o", leds, expected_leds());
      if (divsw1 !== m_divsw1) report_mismatch("divsw1_o", divsw1, m_divsw1);
      if (divsw2 !== m_divsw2) report_mismatch("divsw2_o", divsw2, m_divsw2);
      if (run_rx0 !== |(m_run & ~m_sel)) report_mismatch("run_rx0_o", run_rx0, |(m_run & ~m_sel));
      if (run_rx1 !== |(m_run & m_sel)) report_mismatch("run_rx1_o", run_rx1, |(m_run & m_sel));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus access with random byte-lane bits
   task automatic bus_access(input logic we, input logic [7:0] addr,
                             input logic [31:0] data, output logic [31:0] rdata);
      logic [31:0] lanes;
      logic        got;
      lanes = lcg_next();
      got   = 1'b0;
      rdata = '0;
      @(negedge wb_clk);
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = {addr, lanes[31:30]};
      wb_dat_w = data;
      for (int n = 0; n < ACK_TIMEOUT && !got; n++) begin
         @(negedge wb_clk);
         if (wb_ack) begin
            got   = 1'b1;
            rdata = wb_dat_r;
         end
      end
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      if (!got) abort_run("bus access was not acknowledged within the timeout");
   endtask

   task automatic write_and_settle(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] rdata;
      bus_access(1'b1, addr, data, rdata);
      model_write(addr, data);
      // Register outputs follow one edge after the ack cycle
      repeat (2) @(negedge wb_clk);
   endtask

   // Random ADC traffic checked each cycle against the previous drive
   task automatic run_samples(input int cycles);
      logic [31:0]            r1;
      logic [31:0]            r2;
      logic [31:0]            r3;
      logic [NUM_RX_CHAN-1:0] exp_stb;
      exp_stb = '0;
      for (int cyc = 0; cyc <= cycles; cyc++) begin
         @(negedge wb_clk);
         for (int ch = 0; ch < NUM_RX_CHAN; ch++) begin
            if (cyc > 0 && sample_stb[ch] !== exp_stb[ch])
               report_mismatch($sformatf("sample_stb_o[%0d]", ch), sample_stb[ch], exp_stb[ch]);
            if (cyc > 0 && have_sample[ch] && front_i[ch] !== exp_i[ch])
               report_mismatch($sformatf("front_i_o[%0d]", ch), front_i[ch], exp_i[ch]);
            if (cyc > 0 && have_sample[ch] && front_q[ch] !== exp_q[ch])
               report_mismatch($sformatf("front_q_o[%0d]", ch), front_q[ch], exp_q[ch]);
         end
         r1 = lcg_next();
         r2 = lcg_next();
         r3 = lcg_next();
         adc0_a   = r1[31:20];
         adc0_b   = r1[19:8];
         adc1_a   = r2[31:20];
         adc1_b   = r2[19:8];
         adc0_stb = (cyc < cycles) & r3[31];
         adc1_stb = (cyc < cycles) & r3[30];
         for (int ch = 0; ch < NUM_RX_CHAN; ch++) begin
            exp_stb[ch] = m_run[ch] & (m_sel[ch] ? adc1_stb : adc0_stb);
            if (exp_stb[ch]) begin
               exp_i[ch] = pad_sample(m_sel[ch] ? adc1_a : adc0_a);
               exp_q[ch] = pad_sample(m_sel[ch] ? adc1_b : adc0_b);
               have_sample[ch] = 1'b1;
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      logic [31:0] rnd;
      logic [31:0] rdata;
      logic [7:0]  addr;
      por_rst = 1'b1;
      {wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
      {adc0_a, adc0_b, adc1_a, adc1_b, adc0_stb, adc1_stb} = '0;
      {m_run, m_sel, have_sample, m_led_sw} = '0;
      m_led_src = LED_SRC_AT_RESET;
      {m_divsw1, m_divsw2} = {2{DIVSW_AT_RESET}};
      {err_count, tests_run, tests_failed, test_err_base} = '0;

      // Reset held for 16 edges while the ADC strobes toggle
      for (int n = 0; n < 24; n++) begin
         @(negedge wb_clk);
         if (sample_stb !== '0) report_mismatch("sample_stb_o", sample_stb, 0);
         check_misc();
         if (n == 15) por_rst = 1'b0;
         rnd = lcg_next();
         {adc0_stb, adc1_stb} = rnd[31:30];
      end
      {adc0_stb, adc1_stb} = 2'b00;
      end_test("reset values");

      for (int n = 0; n < MISC_WRITES; n++) begin
         rnd = lcg_next();
         case (rnd[31:30])
            2'd0:    addr = SR_LED_SW;
            2'd1:    addr = SR_LED_SRC;
            2'd2:    addr = SR_DIVSW;
            default: addr = SR_DIVSW + 8'd1;
         endcase
         write_and_settle(addr, lcg_next());
         check_misc();
      end
      end_test("led and diversity writes");

      for (int r = 0; r < CHAN_ROUNDS; r++) begin
         for (int ch = 0; ch < NUM_RX_CHAN; ch++) write_and_settle(SR_RX_CTRL[ch], lcg_next());
         check_misc();
         run_samples(SAMPLE_CYCLES);
      end
      end_test("channel sample path");

      write_and_settle(SR_LED_SRC, 32'h1E);
      write_and_settle(SR_LED_SW, lcg_next());
      for (int r = 0; r < FLAG_ROUNDS; r++) begin
         rnd = lcg_next();
         write_and_settle(SR_RX_CTRL[rnd[31:30]], lcg_next());
         check_misc();
      end
      end_test("frontend activity flags");

      for (int n = 0; n < ODD_ACCESSES; n++) begin
         rnd  = lcg_next();
         addr = rnd[23:16];
         if (rnd[31]) begin
            // Half the reads land on a live channel control word
            if (rnd[30]) addr = SR_RX_CTRL[rnd[29:28]];
            bus_access(1'b0, addr, lcg_next(), rdata);
            if (rdata !== '0) report_mismatch("wb_dat_o", rdata, 0);
         end else begin
            for (int k = 0; k < 16 && is_mapped(addr); k++) addr = addr + 8'd1;
            bus_access(1'b1, addr, lcg_next(), rdata);
         end
         repeat (2) @(negedge wb_clk);
         check_misc();
      end
      end_test("unmapped writes and reads");

      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule
